//--- Makefile
SIM := obj_dir/Vbell_game_tb
SRCS := $(shell grep -v '^+' verilog.f) hdl/bell_consts.svh test/bell_game_model.svh

.PHONY: all run clean

all: run

$(SIM): verilog.f $(SRCS)
	verilator --binary --timing -j 0 --top-module bell_game_tb -f verilog.f

# status comes from grep, so a missing pass line fails the target
run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -F '** PASS **' > /dev/null

clean:
	rm -rf obj_dir

//--- hdl/bell_consts.svh
`ifndef BELL_CONSTS_SVH
`define BELL_CONSTS_SVH

// card fields
`define COLOR_W 2
`define NUM_W 3

`define POT_W 8
`define SCORE_W 10 // signed, two's complement

// decoded keypad codes
`define KEY_W 4
`define KEY_A 4'b0111
`define KEY_B 4'b1001

`define TARGET_NUM 5
`define LEAD_MARGIN 50

// wishbone slave
`define ADR_W 3
`define DAT_W 32

`define ADDR_CARDS 3'd0
`define ADDR_POT 3'd1
`define ADDR_DEAL 3'd2 // write only, pulses deal
`define ADDR_STATUS 3'd3
`define ADDR_SCORE_A 3'd4
`define ADDR_SCORE_B 3'd5

`endif

//--- hdl/bell_game_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "bell_consts.svh"

module bell_game_top import bell_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic [`KEY_W-1:0] keypad,
    input  wire logic              cyc,
    input  wire logic              stb,
    input  wire logic              we,
    input  wire logic [`ADR_W-1:0] adr,
    input  wire logic [`DAT_W-1:0] dat_w,
    output logic      [`DAT_W-1:0] dat_r,
    output logic                   ack
);

    logic [`COLOR_W-1:0] c1;
    logic [`NUM_W-1:0]   n1;
    logic [`COLOR_W-1:0] c2;
    logic [`NUM_W-1:0]   n2;
    logic [`POT_W-1:0]   pot;
    logic                deal;
    logic                ring_ok;
    logic                round_open;
    logic                buzz_valid;
    player_t             ringer;
    score_t              score_a;
    score_t              score_b;
    player_t             leader;

    bell_wb_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .adr        (adr),
        .dat_w      (dat_w),
        .dat_r      (dat_r),
        .ack        (ack),
        .c1         (c1),
        .n1         (n1),
        .c2         (c2),
        .n2         (n2),
        .pot        (pot),
        .deal       (deal),
        .round_open (round_open),
        .ringer     (ringer),
        .ring_ok    (ring_ok),
        .score_a    (score_a),
        .score_b    (score_b),
        .leader     (leader)
    );

    // judge and arbiter run side by side
    card_judge u_judge (
        .clk     (clk),
        .rst     (rst),
        .c1      (c1),
        .n1      (n1),
        .c2      (c2),
        .n2      (n2),
        .ring_ok (ring_ok)
    );

    buzz_arbiter u_arbiter (
        .clk        (clk),
        .rst        (rst),
        .keypad     (keypad),
        .deal       (deal),
        .round_open (round_open),
        .buzz_valid (buzz_valid),
        .ringer     (ringer)
    );

    score_keeper u_score (
        .clk        (clk),
        .rst        (rst),
        .buzz_valid (buzz_valid),
        .ringer     (ringer),
        .ring_ok    (ring_ok),
        .pot        (pot),
        .score_a    (score_a),
        .score_b    (score_b),
        .leader     (leader)
    );

endmodule

`default_nettype wire

//--- hdl/bell_pkg.sv
`default_nettype none

`include "bell_consts.svh"

package bell_pkg;

    // who rang the bell, also used for the leader field
    typedef enum logic [1:0] {
        player_none = 2'b00,
        player_a    = 2'b01,
        player_b    = 2'b10
    } player_t;

    typedef logic signed [`SCORE_W-1:0] score_t;

endpackage

`default_nettype wire

//--- hdl/bell_wb_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "bell_consts.svh"

module bell_wb_regs import bell_pkg::*; (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                cyc,
    input  wire logic                stb,
    input  wire logic                we,
    input  wire logic [`ADR_W-1:0]   adr,
    input  wire logic [`DAT_W-1:0]   dat_w,
    output logic      [`DAT_W-1:0]   dat_r,
    output logic                     ack,
    output logic      [`COLOR_W-1:0] c1,
    output logic      [`NUM_W-1:0]   n1,
    output logic      [`COLOR_W-1:0] c2,
    output logic      [`NUM_W-1:0]   n2,
    output logic      [`POT_W-1:0]   pot,
    output logic                     deal,
    input  wire logic                round_open,
    input  wire player_t             ringer,
    input  wire logic                ring_ok,
    input  wire score_t              score_a,
    input  wire score_t              score_b,
    input  wire player_t             leader
);

    logic              access;
    logic              wr_en;
    logic [`DAT_W-1:0] rd_mux;

    // new request only, the cycle carrying ack is not a second access
    assign access = cyc && stb && !ack;
    assign wr_en = access && we;

    always_comb begin
        rd_mux = '0;
        case (adr)
            `ADDR_CARDS: begin
                rd_mux[1:0]   = c1;
                rd_mux[4:2]   = n1;
                rd_mux[9:8]   = c2;
                rd_mux[12:10] = n2;
            end
            `ADDR_POT: rd_mux[`POT_W-1:0] = pot;
            `ADDR_STATUS: begin
                rd_mux[0]   = round_open;
                rd_mux[3:2] = ringer;
                rd_mux[4]   = ring_ok; // verdict for the cards on the table
                rd_mux[7:6] = leader;
            end
            `ADDR_SCORE_A: rd_mux = {{(`DAT_W-`SCORE_W){score_a[`SCORE_W-1]}}, score_a};
            `ADDR_SCORE_B: rd_mux = {{(`DAT_W-`SCORE_W){score_b[`SCORE_W-1]}}, score_b};
            default: rd_mux = '0; // DEAL reads zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            ack  <= 1'b0;
            deal <= 1'b0;
            c1   <= '0;
            n1   <= '0;
            c2   <= '0;
            n2   <= '0;
            pot  <= '0;
        end else begin
            ack  <= access;
            deal <= wr_en && (adr == `ADDR_DEAL);
            // cards and pot frozen while a round runs
            if (wr_en && !round_open) begin
                if (adr == `ADDR_CARDS) begin
                    c1 <= dat_w[1:0];
                    n1 <= dat_w[4:2];
                    c2 <= dat_w[9:8];
                    n2 <= dat_w[12:10];
                end
                if (adr == `ADDR_POT) begin
                    pot <= dat_w[`POT_W-1:0];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            dat_r <= rd_mux; // valid alongside ack
        end
    end

endmodule

`default_nettype wire

//--- hdl/buzz_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "bell_consts.svh"

module buzz_arbiter import bell_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic [`KEY_W-1:0] keypad,
    input  wire logic              deal,
    output logic                   round_open,
    output logic                   buzz_valid,
    output player_t                ringer
);

    typedef enum logic {
        st_idle,
        st_open
    } arb_state_t;

    arb_state_t state;
    player_t    key_player;
    logic       key_hit;

    // decode the keypad into a player, other codes mean nobody
    always_comb begin
        key_player = player_none;
        if (keypad == `KEY_A) begin
            key_player = player_a;
        end else if (keypad == `KEY_B) begin
            key_player = player_b;
        end
    end

    assign key_hit = (key_player != player_none);
    assign round_open = (state == st_open);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state      <= st_idle;
            buzz_valid <= 1'b0;
            ringer     <= player_none;
        end else begin
            buzz_valid <= 1'b0; // single cycle pulse
            case (state)
                st_idle: begin
                    if (deal) begin
                        state <= st_open;
                    end
                end
                st_open: begin
                    // first key wins, round closes on the same edge
                    if (key_hit) begin
                        state      <= st_idle;
                        buzz_valid <= 1'b1;
                        ringer     <= key_player; // held until next buzz
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/card_judge.sv
`timescale 1ns/1ps
`default_nettype none

`include "bell_consts.svh"

module card_judge (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic [`COLOR_W-1:0] c1,
    input  wire logic [`NUM_W-1:0]   n1,
    input  wire logic [`COLOR_W-1:0] c2,
    input  wire logic [`NUM_W-1:0]   n2,
    output logic                     ring_ok
);

    logic [`NUM_W:0] num_sum; // one bit wider, 7+7 must not wrap
    logic            verdict;

    assign num_sum = {1'b0, n1} + {1'b0, n2};

    always_comb begin
        if (c1 == c2) begin
            verdict = (num_sum == `TARGET_NUM);
        end else begin
            // different colors, a single card has to show the number
            verdict = (n1 == `TARGET_NUM) || (n2 == `TARGET_NUM);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            ring_ok <= 1'b0;
        end else begin
            ring_ok <= verdict;
        end
    end

endmodule

`default_nettype wire

//--- hdl/score_keeper.sv
`timescale 1ns/1ps
`default_nettype none

`include "bell_consts.svh"

module score_keeper import bell_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              buzz_valid,
    input  wire player_t           ringer,
    input  wire logic              ring_ok,
    input  wire logic [`POT_W-1:0] pot,
    output score_t                 score_a,
    output score_t                 score_b,
    output player_t                leader
);

    score_t                  pot_ext;
    logic signed [`SCORE_W:0] diff_ab; // one bit wider than a score
    logic signed [`SCORE_W:0] diff_ba;

    assign pot_ext = score_t'({{(`SCORE_W-`POT_W){1'b0}}, pot});

    assign diff_ab = {score_a[`SCORE_W-1], score_a} - {score_b[`SCORE_W-1], score_b};
    assign diff_ba = {score_b[`SCORE_W-1], score_b} - {score_a[`SCORE_W-1], score_a};

    always_ff @(posedge clk) begin
        if (!rst) begin
            score_a <= '0;
            score_b <= '0;
        end else if (buzz_valid) begin
            case (ringer)
                player_a: begin
                    if (ring_ok) begin
                        score_a <= score_a + pot_ext;
                    end else begin
                        score_a <= score_a - score_t'(1); // penalty
                        score_b <= score_b + score_t'(1);
                    end
                end
                player_b: begin
                    if (ring_ok) begin
                        score_b <= score_b + pot_ext;
                    end else begin
                        score_b <= score_b - score_t'(1);
                        score_a <= score_a + score_t'(1);
                    end
                end
                default: ;
            endcase
        end
    end

    // leader follows the scores one edge later
    always_ff @(posedge clk) begin
        if (!rst) begin
            leader <= player_none;
        end else if (diff_ab > (`SCORE_W+1)'(`LEAD_MARGIN)) begin
            leader <= player_a;
        end else if (diff_ba > (`SCORE_W+1)'(`LEAD_MARGIN)) begin
            leader <= player_b;
        end else begin
            leader <= player_none;
        end
    end

endmodule

`default_nettype wire

//--- test/bell_game_model.svh
`ifndef BELL_GAME_MODEL_SVH
`define BELL_GAME_MODEL_SVH

// expected scores wrap at the score width like the hardware
score_t  exp_a;
score_t  exp_b;
player_t last_who; // ringer and verdict of the last round
logic    last_ok;

// outputs sampled right after an edge still hold the old value
task automatic wait_ack();
    int edges;
    edges = 0;
    do begin
        @(posedge clk);
        edges++;
    end while (ack !== 1'b1);
    check("ack cycles after request", edges, 2); // request sampled on the first edge
endtask

task automatic wb_write(input logic [`ADR_W-1:0] addr, input logic [`DAT_W-1:0] data);
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= 1'b1;
    adr   <= addr;
    dat_w <= data;
    wait_ack();
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
endtask

task automatic wb_read(input logic [`ADR_W-1:0] addr, output logic [`DAT_W-1:0] data);
    @(posedge clk);
    cyc <= 1'b1;
    stb <= 1'b1;
    we  <= 1'b0;
    adr <= addr;
    wait_ack();
    data = dat_r;
    cyc <= 1'b0;
    stb <= 1'b0;
endtask

// second key lands the cycle after the first
task automatic press_keys(input logic [`KEY_W-1:0] first, input logic [`KEY_W-1:0] second);
    @(posedge clk);
    keypad <= first;
    @(posedge clk);
    keypad <= second;
    @(posedge clk);
    keypad <= key_idle;
    repeat (2) @(posedge clk); // scores then leader
endtask

function automatic logic [`DAT_W-1:0] pack_cards(input logic [`COLOR_W-1:0] c1,
                                                 input logic [`NUM_W-1:0] n1,
                                                 input logic [`COLOR_W-1:0] c2,
                                                 input logic [`NUM_W-1:0] n2);
    logic [`DAT_W-1:0] word;
    word = '0;
    word[1:0]   = c1;
    word[4:2]   = n1;
    word[9:8]   = c2;
    word[12:10] = n2;
    return word;
endfunction

// same color needs the sum and different colors need one card showing it
function automatic logic judge_cards(input logic [`COLOR_W-1:0] c1,
                                     input logic [`NUM_W-1:0] n1,
                                     input logic [`COLOR_W-1:0] c2,
                                     input logic [`NUM_W-1:0] n2);
    if (c1 == c2) begin
        return (int'(n1) + int'(n2)) == `TARGET_NUM;
    end
    return (int'(n1) == `TARGET_NUM) || (int'(n2) == `TARGET_NUM);
endfunction

function automatic void model_score(input player_t who, input logic ok,
                                    input logic [`POT_W-1:0] pot);
    int a;
    int b;
    a = int'(exp_a);
    b = int'(exp_b);
    if (who == player_a) begin
        if (ok) begin
            a = a + int'(pot);
        end else begin
            a = a - 1;
            b = b + 1;
        end
    end else if (who == player_b) begin
        if (ok) begin
            b = b + int'(pot);
        end else begin
            b = b - 1;
            a = a + 1;
        end
    end
    exp_a    = score_t'(a);
    exp_b    = score_t'(b);
    last_who = who;
    last_ok  = ok;
endfunction

function automatic player_t model_leader();
    int lead;
    lead = int'(exp_a) - int'(exp_b);
    if (lead > `LEAD_MARGIN) begin
        return player_a;
    end
    if (-lead > `LEAD_MARGIN) begin
        return player_b;
    end
    return player_none;
endfunction

`endif

//--- test/bell_game_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "bell_consts.svh"

module bell_game_tb import bell_pkg::*; ();

    localparam int max_steps = 16; // leader rounds per phase
    localparam int planned_rounds = 2 + 60 + 60 + 4 + 4 * max_steps;
    localparam int cycle_limit = 200 * planned_rounds + 500;
    localparam logic [`KEY_W-1:0] key_idle = 4'h0;

    logic              clk = 1'b0;
    logic              rst;
    logic [`KEY_W-1:0] keypad;
    logic              cyc;
    logic              stb;
    logic              we;
    logic [`ADR_W-1:0] adr;
    logic [`DAT_W-1:0] dat_w;
    logic [`DAT_W-1:0] dat_r;
    logic              ack;
    int                seed;
    int                errors;
    int                tests;

    bell_game_top u_dut (
        .clk    (clk),
        .rst    (rst),
        .keypad (keypad),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .dat_w  (dat_w),
        .dat_r  (dat_r),
        .ack    (ack)
    );

    `include "bell_game_model.svh"

    always #20 clk = ~clk;

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("ERROR at %0t: %s, got %0h, expected %0h", $time, what, got, want);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d (%s) done, %0d errors so far", tests, name, errors);
    endtask

    function automatic logic [`KEY_W-1:0] key_of(input player_t who);
        return (who == player_b) ? `KEY_B : `KEY_A;
    endfunction

    task automatic deal_cards(input logic [`COLOR_W-1:0] c1, input logic [`NUM_W-1:0] n1,
                              input logic [`COLOR_W-1:0] c2, input logic [`NUM_W-1:0] n2,
                              input logic [`POT_W-1:0] pot);
        logic [`DAT_W-1:0] rd;
        wb_write(`ADDR_CARDS, pack_cards(c1, n1, c2, n2));
        wb_write(`ADDR_POT, 32'(pot));
        wb_write(`ADDR_DEAL, 32'h1);
        wb_read(`ADDR_STATUS, rd);
        check("round open after deal", 32'(rd[0]), 32'd1);
    endtask

    task automatic check_round(input player_t who, input logic ok);
        logic [`DAT_W-1:0] rd;
        wb_read(`ADDR_STATUS, rd);
        check("round closed after buzz", 32'(rd[0]), 32'd0);
        check("ringer", 32'(rd[3:2]), 32'(who));
        check("verdict", 32'(rd[4]), 32'(ok));
        check("leader", 32'(rd[7:6]), 32'(model_leader()));
        wb_read(`ADDR_SCORE_A, rd);
        check("score a", rd, 32'(exp_a));
        wb_read(`ADDR_SCORE_B, rd);
        check("score b", rd, 32'(exp_b));
    endtask

    task automatic play_round(input logic [`COLOR_W-1:0] c1, input logic [`NUM_W-1:0] n1,
                              input logic [`COLOR_W-1:0] c2, input logic [`NUM_W-1:0] n2,
                              input logic [`POT_W-1:0] pot, input player_t who,
                              input logic [`KEY_W-1:0] late_key);
        logic ok;
        ok = judge_cards(c1, n1, c2, n2);
        deal_cards(c1, n1, c2, n2, pot);
        press_keys(key_of(who), late_key);
        model_score(who, ok, pot);
        check_round(who, ok);
    endtask

    task automatic random_round(input logic [`POT_W-1:0] pot_mask);
        logic [31:0] r;
        r = $random(seed);
        play_round(r[1:0], r[4:2], r[9:8], r[12:10], r[31:24] & pot_mask,
                   r[16] ? player_b : player_a, key_idle);
    endtask

    // ring correct pairs for one player until the leader field reaches target
    task automatic drive_lead(input player_t who, input player_t target);
        int steps;
        steps = 0;
        while (model_leader() != target && steps < max_steps) begin
            play_round(2'd0, 3'd2, 2'd0, 3'd3, (target == player_none) ? 8'd20 : 8'd60,
                       who, key_idle);
            steps++;
        end
        if (model_leader() != target) begin
            $display("leader test did not reach the wanted leader in %0d rounds", max_steps);
            errors++;
        end
    endtask

    initial begin : stimulus
        logic [31:0] r;
        logic [31:0] rd;
        rst      <= 1'b0;
        keypad   <= key_idle;
        cyc      <= 1'b0;
        stb      <= 1'b0;
        we       <= 1'b0;
        adr      <= '0;
        dat_w    <= '0;
        seed     = 11;
        errors   = 0;
        tests    = 0;
        exp_a    = '0;
        exp_b    = '0;
        last_who = player_none;
        last_ok  = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b1;

        wb_read(`ADDR_STATUS, rd);
        check("status after reset", rd, 32'h0);
        wb_read(`ADDR_SCORE_A, rd);
        check("score a after reset", rd, 32'h0);
        wb_read(`ADDR_SCORE_B, rd);
        check("score b after reset", rd, 32'h0);
        repeat (4) begin
            r = $random(seed);
            wb_write(`ADDR_CARDS, pack_cards(r[1:0], r[4:2], r[9:8], r[12:10]));
            wb_read(`ADDR_CARDS, rd);
            check("cards readback", rd, pack_cards(r[1:0], r[4:2], r[9:8], r[12:10]));
            wb_write(`ADDR_POT, 32'(r[31:24]));
            wb_read(`ADDR_POT, rd);
            check("pot readback", rd, 32'(r[31:24]));
        end
        end_test("reset and registers");

        repeat (60) random_round(8'h00); // zero pot so only the penalty moves the scores
        end_test("verdict rule");

        repeat (60) random_round(8'h3f);
        end_test("scoring");

        // keys with no round open
        press_keys(`KEY_A, `KEY_B);
        check_round(last_who, last_ok);
        play_round(2'd1, 3'd5, 2'd2, 3'd0, 8'd7, player_a, `KEY_B);
        deal_cards(2'd0, 3'd1, 2'd0, 3'd4, 8'd9);
        wb_write(`ADDR_CARDS, pack_cards(2'd3, 3'd0, 2'd1, 3'd0)); // dropped while open
        wb_read(`ADDR_CARDS, rd);
        check("cards locked during round", rd, pack_cards(2'd0, 3'd1, 2'd0, 3'd4));
        press_keys(`KEY_B, `KEY_A);
        model_score(player_b, judge_cards(2'd0, 3'd1, 2'd0, 3'd4), 8'd9);
        check_round(player_b, judge_cards(2'd0, 3'd1, 2'd0, 3'd4));
        end_test("buzz arbitration");

        drive_lead(player_a, player_a);
        drive_lead(player_b, player_none);
        drive_lead(player_b, player_b);
        drive_lead(player_a, player_none);
        end_test("leader flag");

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, the run did not finish within %0d cycles", cycle_limit);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+hdl
+incdir+test
hdl/bell_pkg.sv
hdl/card_judge.sv
hdl/buzz_arbiter.sv
hdl/score_keeper.sv
hdl/bell_wb_regs.sv
hdl/bell_game_top.sv
test/bell_game_tb.sv
